/* axi_line_pkg.sv */
// axi line adapter definitions
// widths, cache request type, reduced AXI channel structs and burst
// constants shared by the adapter stages
`default_nettype none

package axi_line_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  localparam int unsigned ADDR_WIDTH       = 32;
  localparam int unsigned DATA_WIDTH       = 64;
  localparam int unsigned STRB_WIDTH       = DATA_WIDTH / 8;
  localparam int unsigned ID_WIDTH         = 4;
  localparam int unsigned BEATS_PER_LINE   = 4;
  localparam int unsigned BEAT_IDX_WIDTH   = 2;
  localparam int unsigned LINE_OFFSET_BITS = 5;
  localparam int unsigned BEAT_OFFSET_BITS = 3;

  // --------------------------------------------------
  // burst constants
  // --------------------------------------------------
  localparam logic [7:0] SINGLE_LEN = 8'd0;
  localparam logic [7:0] LINE_LEN   = 8'(BEATS_PER_LINE - 1);
  localparam logic [BEAT_IDX_WIDTH-1:0] LAST_BEAT = BEAT_IDX_WIDTH'(BEATS_PER_LINE - 1);

  // --------------------------------------------------
  // request side
  // --------------------------------------------------
  typedef enum logic {
    SINGLE_REQ,
    LINE_REQ
  } req_kind_e;

  typedef logic [BEATS_PER_LINE-1:0][DATA_WIDTH-1:0] line_data_t;
  typedef logic [BEATS_PER_LINE-1:0][STRB_WIDTH-1:0] line_strb_t;

  typedef struct packed {
    req_kind_e             kind;
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;
    logic [1:0]            size;
    logic [ID_WIDTH-1:0]   id;
    line_data_t            wdata;
    line_strb_t            be;
  } line_req_t;

  // --------------------------------------------------
  // AXI side
  // --------------------------------------------------
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [ID_WIDTH-1:0]   id;
  } axi_addr_t;

  typedef struct packed {
    logic                  aw_valid;
    axi_addr_t             aw;
    logic                  w_valid;
    logic [DATA_WIDTH-1:0] w_data;
    logic [STRB_WIDTH-1:0] w_strb;
    logic                  w_last;
    logic                  b_ready;
    logic                  ar_valid;
    axi_addr_t             ar;
    logic                  r_ready;
  } axi_req_t;

  typedef struct packed {
    logic                  aw_ready;
    logic                  w_ready;
    logic                  b_valid;
    logic [ID_WIDTH-1:0]   b_id;
    logic [1:0]            b_resp;
    logic                  ar_ready;
    logic                  r_valid;
    logic [DATA_WIDTH-1:0] r_data;
    logic [ID_WIDTH-1:0]   r_id;
    logic                  r_last;
  } axi_rsp_t;

  // decode result handed to the execute stage
  typedef struct packed {
    axi_addr_t                 ax;
    logic [BEAT_IDX_WIDTH-1:0] crit_idx;
    logic                      is_line;
  } addr_phase_t;

endpackage

`default_nettype wire

/* axi_req_decode.sv */
// request decode
// turns a cache request into the AXI address-phase fields shared by
// AW and AR, and extracts the beat index of the critical word
`timescale 1ns/1ps
`default_nettype none

module axi_req_decode (
  input  axi_line_pkg::line_req_t   req_i_data,
  output axi_line_pkg::addr_phase_t phase_o
);

  logic                                  is_line;
  logic [axi_line_pkg::ADDR_WIDTH-1:0]   line_addr;

  assign is_line = (req_i_data.kind == axi_line_pkg::LINE_REQ);

  // line bursts are incrementing from the line base
  always_comb begin
    line_addr = req_i_data.addr;
    line_addr[axi_line_pkg::LINE_OFFSET_BITS-1:0] = '0;
  end

  // --------------------------------------------------
  // address phase
  // --------------------------------------------------
  always_comb begin
    phase_o.ax.id   = req_i_data.id;
    // 1, 2, 4 or 8 bytes per beat
    phase_o.ax.size = {1'b0, req_i_data.size};
    if (is_line) begin
      phase_o.ax.addr = line_addr;
      phase_o.ax.len  = axi_line_pkg::LINE_LEN;
    end else begin
      phase_o.ax.addr = req_i_data.addr;
      phase_o.ax.len  = axi_line_pkg::SINGLE_LEN;
    end
  end

  // word offset inside the line selects the critical beat
  assign phase_o.crit_idx =
    req_i_data.addr[axi_line_pkg::BEAT_OFFSET_BITS +: axi_line_pkg::BEAT_IDX_WIDTH];

  assign phase_o.is_line = is_line;

endmodule

`default_nettype wire

/* axi_burst_fsm.sv */
// execute stage
// sequences the AW, W, B, AR and R handshakes of one request at a time,
// counts the W beats of a line burst and produces grant, write
// completion and busy
`timescale 1ns/1ps
`default_nettype none

module axi_burst_fsm (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                req_i,
  input  axi_line_pkg::line_req_t             req_i_data,
  input  axi_line_pkg::addr_phase_t           phase_i,
  input  axi_line_pkg::axi_rsp_t              axi_rsp_i,
  output axi_line_pkg::axi_req_t              axi_req_o,
  output logic                                gnt_o,
  output logic                                valid_o,
  output logic                                busy_o,
  output logic                                start_o,
  output logic                                beat_fire_o,
  output logic [axi_line_pkg::ID_WIDTH-1:0]   wid_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_AW_W,
    WAIT_AW,
    WAIT_W,
    WAIT_B,
    WAIT_R
  } state_e;

  state_e state_q, state_d;

  // W beats still to send after the current one
  logic [axi_line_pkg::BEAT_IDX_WIDTH-1:0] cnt_q, cnt_d;
  logic [axi_line_pkg::BEAT_IDX_WIDTH-1:0] w_rem;
  logic [axi_line_pkg::BEAT_IDX_WIDTH-1:0] w_idx;
  logic                                    new_write;
  logic                                    aw_pend;
  logic                                    w_pend;
  logic                                    w_last;
  logic                                    aw_done;
  logic                                    w_done;

  assign new_write = (state_q == IDLE) && req_i && req_i_data.we;

  // a new write starts with the full beat count
  assign w_rem = (state_q == IDLE) ?
                 (phase_i.is_line ? axi_line_pkg::LAST_BEAT : '0) : cnt_q;
  assign w_idx  = phase_i.is_line ? (axi_line_pkg::LAST_BEAT - w_rem) : '0;
  assign w_last = (w_rem == '0);

  assign aw_pend = new_write || (state_q == WAIT_AW_W) || (state_q == WAIT_AW);
  assign w_pend  = new_write || (state_q == WAIT_AW_W) || (state_q == WAIT_W);

  // each half counts as done once nothing of it is left after this cycle
  assign aw_done = !aw_pend || axi_rsp_i.aw_ready;
  assign w_done  = !w_pend || (axi_rsp_i.w_ready && w_last);

  assign busy_o      = (state_q != IDLE);
  assign beat_fire_o = (state_q == WAIT_R) && axi_rsp_i.r_valid;
  assign wid_o       = axi_rsp_i.b_id;

  // --------------------------------------------------
  // next state and AXI drive
  // --------------------------------------------------
  always_comb begin
    axi_req_o          = '0;
    axi_req_o.aw       = phase_i.ax;
    axi_req_o.ar       = phase_i.ax;
    axi_req_o.aw_valid = aw_pend;
    axi_req_o.w_valid  = w_pend;
    axi_req_o.w_data   = req_i_data.wdata[w_idx];
    axi_req_o.w_strb   = req_i_data.be[w_idx];
    axi_req_o.w_last   = w_last;

    gnt_o   = 1'b0;
    valid_o = 1'b0;
    start_o = 1'b0;
    state_d = state_q;
    cnt_d   = cnt_q;

    case (state_q)
      IDLE: begin
        // writes are taken by the shared write path below
        if (req_i && !req_i_data.we) begin
          axi_req_o.ar_valid = 1'b1;
          if (axi_rsp_i.ar_ready) begin
            gnt_o   = 1'b1;
            start_o = 1'b1;
            state_d = WAIT_R;
          end
        end
      end
      WAIT_B: begin
        axi_req_o.b_ready = 1'b1;
        if (axi_rsp_i.b_valid) begin
          valid_o = 1'b1;
          state_d = IDLE;
        end
      end
      WAIT_R: begin
        axi_req_o.r_ready = 1'b1;
        if (axi_rsp_i.r_valid && axi_rsp_i.r_last) begin
          state_d = IDLE;
        end
      end
      default: ;
    endcase

    // address and data halves of a write
    if (aw_pend || w_pend) begin
      cnt_d = (w_pend && axi_rsp_i.w_ready && !w_last) ? w_rem - 1'b1 : w_rem;
      case ({aw_done, w_done})
        2'b11: begin
          gnt_o   = 1'b1;
          state_d = WAIT_B;
        end
        2'b10:   state_d = WAIT_W;
        2'b01:   state_d = WAIT_AW;
        default: state_d = WAIT_AW_W;
      endcase
    end
  end

  // --------------------------------------------------
  // registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

`default_nettype wire

/* axi_line_assembler.sv */
// result stage
// collects read beats into the line register, flags the critical word
// as it arrives and signals read completion one cycle after the last beat
`timescale 1ns/1ps
`default_nettype none

module axi_line_assembler (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      start_i,
  input  logic                                      beat_fire_i,
  input  logic                                      is_line_i,
  input  logic [axi_line_pkg::BEAT_IDX_WIDTH-1:0]   crit_idx_i,
  input  axi_line_pkg::axi_rsp_t                    axi_rsp_i,
  output axi_line_pkg::line_data_t                  rdata_o,
  output logic [axi_line_pkg::ID_WIDTH-1:0]         id_o,
  output logic                                      valid_o,
  output logic [axi_line_pkg::DATA_WIDTH-1:0]       critical_word_o,
  output logic                                      critical_word_valid_o
);

  logic [axi_line_pkg::BEAT_IDX_WIDTH-1:0] cnt_q;
  logic [axi_line_pkg::BEAT_IDX_WIDTH-1:0] crit_q;
  logic [axi_line_pkg::BEAT_IDX_WIDTH-1:0] slot;
  logic                                    is_line_q;
  logic                                    valid_q;
  logic [axi_line_pkg::ID_WIDTH-1:0]       id_q;
  axi_line_pkg::line_data_t                line_q;

  // single reads always land in slot 0
  assign slot = is_line_q ? cnt_q : '0;

  assign critical_word_o       = axi_rsp_i.r_data;
  assign critical_word_valid_o = beat_fire_i && (!is_line_q || (cnt_q == crit_q));

  assign rdata_o = line_q;
  assign id_o    = id_q;
  assign valid_o = valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      crit_q    <= '0;
      is_line_q <= 1'b0;
      valid_q   <= 1'b0;
      line_q    <= '0;
    end else begin
      valid_q <= beat_fire_i && axi_rsp_i.r_last;
      if (start_i) begin
        cnt_q     <= '0;
        crit_q    <= crit_idx_i;
        is_line_q <= is_line_i;
      end else if (beat_fire_i) begin
        cnt_q <= cnt_q + 1'b1;
      end
      if (beat_fire_i) begin
        line_q[slot] <= axi_rsp_i.r_data;
      end
    end
  end

  // id of the closing beat goes out with valid_o
  always_ff @(posedge clk_i) begin
    if (beat_fire_i && axi_rsp_i.r_last) begin
      id_q <= axi_rsp_i.r_id;
    end
  end

endmodule

`default_nettype wire

/* axi_line_adapter.sv */
// cache-side AXI master adapter
// accepts one single-beat or cache-line request at a time and runs it
// as an AXI4 burst; decode, execute and result stages live below
`timescale 1ns/1ps
`default_nettype none

module axi_line_adapter (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  req_i,
  input  axi_line_pkg::line_req_t               req_data_i,
  output logic                                  gnt_o,
  output logic                                  busy_o,
  output logic                                  valid_o,
  output logic [axi_line_pkg::ID_WIDTH-1:0]     id_o,
  output axi_line_pkg::line_data_t              rdata_o,
  output logic [axi_line_pkg::DATA_WIDTH-1:0]   critical_word_o,
  output logic                                  critical_word_valid_o,
  output axi_line_pkg::axi_req_t                axi_req_o,
  input  axi_line_pkg::axi_rsp_t                axi_rsp_i
);

  axi_line_pkg::addr_phase_t               phase;
  axi_line_pkg::line_data_t                line_data;
  logic                                    wr_valid;
  logic                                    rd_valid;
  logic [axi_line_pkg::ID_WIDTH-1:0]       wr_id;
  logic [axi_line_pkg::ID_WIDTH-1:0]       rd_id;
  logic                                    start;
  logic                                    beat_fire;
  logic                                    is_line;

  // --------------------------------------------------
  // stages
  // --------------------------------------------------
  axi_req_decode u_decode (
    .req_i_data (req_data_i),
    .phase_o    (phase)
  );

  axi_burst_fsm u_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_i_data  (req_data_i),
    .phase_i     (phase),
    .axi_rsp_i   (axi_rsp_i),
    .axi_req_o   (axi_req_o),
    .gnt_o       (gnt_o),
    .valid_o     (wr_valid),
    .busy_o      (busy_o),
    .start_o     (start),
    .beat_fire_o (beat_fire),
    .wid_o       (wr_id)
  );

  assign is_line = phase.is_line;

  axi_line_assembler u_assembler (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .start_i               (start),
    .beat_fire_i           (beat_fire),
    .is_line_i             (is_line),
    .crit_idx_i            (phase.crit_idx),
    .axi_rsp_i             (axi_rsp_i),
    .rdata_o               (line_data),
    .id_o                  (rd_id),
    .valid_o               (rd_valid),
    .critical_word_o       (critical_word_o),
    .critical_word_valid_o (critical_word_valid_o)
  );

  // write and read completions never fall in the same cycle
  assign valid_o = wr_valid | rd_valid;
  assign id_o    = rd_valid ? rd_id : wr_id;
  // a write leaves the line register as it was
  assign rdata_o = line_data;

endmodule

`default_nettype wire

/* axi_line_adapter_chk.sv */
// AXI protocol checker for the line adapter
// valid hold rules, w_last placement, reset quiet outputs and a single
// critical word per read
`timescale 1ns/1ps
`default_nettype none

module axi_line_adapter_chk (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   gnt_o,
  input logic                   valid_o,
  input logic                   start_i,
  input logic                   critical_word_valid_o,
  input axi_line_pkg::axi_req_t axi_req_i,
  input axi_line_pkg::axi_rsp_t axi_rsp_i
);

  logic [7:0] w_beat_q;
  logic       crit_seen_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_beat_q    <= '0;
      crit_seen_q <= 1'b0;
    end else begin
      if (axi_req_i.w_valid && axi_rsp_i.w_ready) begin
        w_beat_q <= axi_req_i.w_last ? 8'd0 : w_beat_q + 8'd1;
      end
      if (start_i) begin
        crit_seen_q <= 1'b0;
      end else if (critical_word_valid_o) begin
        crit_seen_q <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // valid hold
  // --------------------------------------------------
  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_req_i.aw_valid && !axi_rsp_i.aw_ready |=> axi_req_i.aw_valid)
    else $error("aw_valid dropped before aw_ready");
  w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_req_i.w_valid && !axi_rsp_i.w_ready |=> axi_req_i.w_valid)
    else $error("w_valid dropped before w_ready");
  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_req_i.ar_valid && !axi_rsp_i.ar_ready |=> axi_req_i.ar_valid)
    else $error("ar_valid dropped before ar_ready");

  // last beat sits exactly at len
  w_last_pos: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_req_i.w_valid |-> (axi_req_i.w_last == (w_beat_q == axi_req_i.aw.len)))
    else $error("w_last not on beat len");

  reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !gnt_o && !valid_o)
    else $error("grant or completion during reset");

  crit_once: assert property (@(posedge clk_i) disable iff (!rst_ni)
    critical_word_valid_o |-> !crit_seen_q)
    else $error("second critical word in one read");

endmodule

`default_nettype wire

/* tb_axi_line_adapter.sv */
// testbench for the cache-side AXI line adapter
// AXI slave memory model with random stalls, request stimulus and checks
`timescale 1ns/1ps
`default_nettype none

module tb_axi_line_adapter;

  localparam int TIMEOUT = 200;

  logic                               clk_i;
  logic                               rst_ni;
  logic                               req_i;
  axi_line_pkg::line_req_t            req_data;
  logic                               gnt_o;
  logic                               busy_o;
  logic                               valid_o;
  logic [axi_line_pkg::ID_WIDTH-1:0]  id_o;
  axi_line_pkg::line_data_t           rdata_o;
  logic [63:0]                        critical_word_o;
  logic                               critical_word_valid_o;
  axi_line_pkg::axi_req_t             axi_req;
  axi_line_pkg::axi_rsp_t             axi_rsp;

  logic [31:0]                        lfsr_q = 32'hf3d4_03e5;
  logic [63:0]                        mem [64];
  int                                 errors;
  int                                 tests;
  int                                 failed;
  int                                 gnt_cnt;
  int                                 valid_cnt;
  int                                 crit_cnt;
  logic [63:0]                        crit_word;
  logic [axi_line_pkg::ID_WIDTH-1:0]  got_id;
  axi_line_pkg::line_data_t           got_rdata;
  axi_line_pkg::axi_addr_t            aw_seen;
  axi_line_pkg::axi_addr_t            ar_seen;
  logic [63:0]                        w_data_q [$];
  logic [7:0]                         w_strb_q [$];
  logic                               w_last_q [$];

  axi_line_adapter dut (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .req_i                 (req_i),
    .req_data_i            (req_data),
    .gnt_o                 (gnt_o),
    .busy_o                (busy_o),
    .valid_o               (valid_o),
    .id_o                  (id_o),
    .rdata_o               (rdata_o),
    .critical_word_o       (critical_word_o),
    .critical_word_valid_o (critical_word_valid_o),
    .axi_req_o             (axi_req),
    .axi_rsp_i             (axi_rsp)
  );

  bind axi_line_adapter axi_line_adapter_chk u_chk (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .gnt_o                 (gnt_o),
    .valid_o               (valid_o),
    .start_i               (start),
    .critical_word_valid_o (critical_word_valid_o),
    .axi_req_i             (axi_req_o),
    .axi_rsp_i             (axi_rsp_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // galois LFSR, one step per bit taken
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  task automatic report(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout: no %s within %0d cycles", what, TIMEOUT);
    errors++;
  endtask

  // ready rises a random 0 to 3 cycles after valid is seen
  task automatic ready_step(input logic v, input logic hs, inout logic rdy, inout int dly);
    if (hs) begin
      rdy = 1'b0;
      dly = -1;
    end else if (v && !rdy) begin
      if (dly < 0) dly = int'(take_bits(2));
      if (dly == 0) begin
        rdy = 1'b1;
        dly = -1;
      end else begin
        dly--;
      end
    end
  endtask

  // --------------------------------------------------
  // AXI slave memory model
  // --------------------------------------------------
  initial begin : slave_model
    logic aw_hs, w_hs, b_hs, ar_hs, r_hs;
    logic aw_v, w_v, ar_v;
    logic aw_got, wl_got;
    int   aw_dly, w_dly, ar_dly, b_dly, r_dly, r_left, r_beat;
    logic [5:0] idx;
    logic [5:0] r_base;
    axi_rsp = '0;
    aw_got = 1'b0;
    wl_got = 1'b0;
    aw_dly = -1;
    w_dly = -1;
    ar_dly = -1;
    b_dly = -1;
    r_dly = -1;
    r_left = 0;
    r_beat = 0;
    r_base = '0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = {32'(i * 8) ^ 32'h5a3c_0000, ~32'(i * 8)};
    end
    forever begin
      // sample handshakes that complete at the coming edge
      @(negedge clk_i);
      aw_v  = axi_req.aw_valid;
      w_v   = axi_req.w_valid;
      ar_v  = axi_req.ar_valid;
      aw_hs = aw_v && axi_rsp.aw_ready;
      w_hs  = w_v && axi_rsp.w_ready;
      ar_hs = ar_v && axi_rsp.ar_ready;
      b_hs  = axi_rsp.b_valid && axi_req.b_ready;
      r_hs  = axi_rsp.r_valid && axi_req.r_ready;
      if (aw_hs) begin
        aw_seen = axi_req.aw;
        aw_got  = 1'b1;
      end
      if (w_hs) begin
        w_data_q.push_back(axi_req.w_data);
        w_strb_q.push_back(axi_req.w_strb);
        w_last_q.push_back(axi_req.w_last);
        if (axi_req.w_last) wl_got = 1'b1;
      end
      if (ar_hs) begin
        ar_seen = axi_req.ar;
        r_base = axi_req.ar.addr[8:3];
        r_left = int'(axi_req.ar.len) + 1;
        r_beat = 0;
      end
      @(posedge clk_i);
      #2;
      ready_step(aw_v, aw_hs, axi_rsp.aw_ready, aw_dly);
      ready_step(w_v, w_hs, axi_rsp.w_ready, w_dly);
      ready_step(ar_v, ar_hs, axi_rsp.ar_ready, ar_dly);
      if (b_hs) axi_rsp.b_valid = 1'b0;
      if (aw_got && wl_got && !axi_rsp.b_valid) begin
        if (b_dly < 0) b_dly = int'(take_bits(2));
        if (b_dly == 0) begin
          // commit the strobed bytes of every beat
          for (int k = 0; k < w_data_q.size(); k++) begin
            idx = aw_seen.addr[8:3] + 6'(k);
            for (int b = 0; b < 8; b++) begin
              if (w_strb_q[k][b]) mem[idx][b*8 +: 8] = w_data_q[k][b*8 +: 8];
            end
          end
          axi_rsp.b_valid = 1'b1;
          axi_rsp.b_id    = aw_seen.id;
          axi_rsp.b_resp  = 2'b00;
          aw_got = 1'b0;
          wl_got = 1'b0;
          b_dly  = -1;
        end else begin
          b_dly--;
        end
      end
      if (r_hs) begin
        axi_rsp.r_valid = 1'b0;
        r_beat++;
        r_left--;
      end
      if (r_left > 0 && !axi_rsp.r_valid) begin
        if (r_dly < 0) r_dly = int'(take_bits(2));
        if (r_dly == 0) begin
          axi_rsp.r_valid = 1'b1;
          axi_rsp.r_data  = mem[r_base + 6'(r_beat)];
          axi_rsp.r_id    = ar_seen.id;
          axi_rsp.r_last  = (r_left == 1);
          r_dly = -1;
        end else begin
          r_dly--;
        end
      end
    end
  end

  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (gnt_o) gnt_cnt++;
      if (valid_o) valid_cnt++;
      if (critical_word_valid_o) begin
        crit_cnt++;
        crit_word = critical_word_o;
      end
    end
  end

  // one request from offer to completion, then the idle checks
  task automatic run_req(input axi_line_pkg::line_req_t r);
    int n;
    gnt_cnt = 0;
    valid_cnt = 0;
    crit_cnt = 0;
    w_data_q.delete();
    w_strb_q.delete();
    w_last_q.delete();
    @(posedge clk_i);
    #2;
    req_data = r;
    req_i = 1'b1;
    n = 0;
    @(negedge clk_i);
    while (!gnt_o && n < TIMEOUT) begin
      n++;
      @(negedge clk_i);
    end
    if (!gnt_o) begin
      timeout_fail("grant");
      return;
    end
    @(posedge clk_i);
    #2;
    req_i = 1'b0;
    n = 0;
    @(negedge clk_i);
    assert (busy_o) else report("busy_o low while the request is in flight");
    while (!valid_o && n < TIMEOUT) begin
      n++;
      @(negedge clk_i);
    end
    if (!valid_o) begin
      timeout_fail("completion");
      return;
    end
    got_id = id_o;
    got_rdata = rdata_o;
    assert (gnt_cnt == 1) else report("grant count before completion is not 1");
    repeat (2) @(negedge clk_i);
    assert (!busy_o) else report("busy_o still high after completion");
    assert (valid_cnt == 1) else report("valid_o did not fire exactly once");
    assert (got_id == r.id) else report("id_o differs from request id");
  endtask

  function automatic axi_line_pkg::line_req_t make_req(
    input logic line, input logic we, input logic [31:0] addr, input logic [3:0] id);
    axi_line_pkg::line_req_t r;
    r = '0;
    r.kind = line ? axi_line_pkg::LINE_REQ : axi_line_pkg::SINGLE_REQ;
    r.we   = we;
    r.addr = addr;
    r.size = 2'd3;
    r.id   = id;
    return r;
  endfunction

  task automatic close_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: FAILED", name);
    end
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin : stimulus
    axi_line_pkg::line_req_t r;
    logic [63:0] exp_word;
    int e;
    req_i = 1'b0;
    req_data = '0;
    rst_ni = 1'b0;
    errors = 0;
    tests = 0;
    failed = 0;
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    e = errors;
    repeat (4) begin
      @(negedge clk_i);
      assert (!busy_o && !gnt_o && !valid_o && !critical_word_valid_o)
        else report("outputs active after reset");
      assert (!axi_req.aw_valid && !axi_req.w_valid && !axi_req.ar_valid)
        else report("AXI valid high before first request");
      assert (!axi_req.b_ready && !axi_req.r_ready) else report("AXI ready high after reset");
      assert (rdata_o == '0) else report("line register not cleared by reset");
    end
    close_test("reset", e);

    // single write with a partial strobe
    e = errors;
    r = make_req(1'b0, 1'b1, 32'h48, 4'd5);
    r.wdata[0] = take_bits(64);
    r.be[0] = 8'h3c;
    exp_word = mem[9];
    for (int b = 2; b < 6; b++) exp_word[b*8 +: 8] = r.wdata[0][b*8 +: 8];
    run_req(r);
    assert (aw_seen.addr == 32'h48 && aw_seen.len == 8'd0 && aw_seen.size == 3'd3)
      else report("single AW fields");
    assert (w_data_q.size() == 1) else report("single write beat count");
    assert (w_data_q[0] == r.wdata[0] && w_strb_q[0] == 8'h3c && w_last_q[0])
      else report("single W beat");
    assert (mem[9] == exp_word) else report("memory word after single write");
    close_test("single_write", e);

    // line write from an unaligned address
    e = errors;
    r = make_req(1'b1, 1'b1, 32'h6c, 4'd9);
    for (int k = 0; k < 4; k++) r.wdata[k] = take_bits(64);
    r.be = '1;
    run_req(r);
    assert (aw_seen.addr == 32'h60 && aw_seen.len == 8'd3 && aw_seen.size == 3'd3)
      else report("line AW fields");
    assert (w_data_q.size() == 4) else report("line write beat count");
    for (int k = 0; k < w_data_q.size(); k++) begin
      assert (w_data_q[k] == r.wdata[k]) else report("line W data order");
      assert (w_last_q[k] == (k == 3)) else report("line W last position");
    end
    close_test("line_write", e);

    // read the written line back, critical beat 1
    e = errors;
    exp_word = r.wdata[1];
    got_rdata = r.wdata;
    r = make_req(1'b1, 1'b0, 32'h68, 4'd3);
    r.wdata = got_rdata;
    run_req(r);
    assert (ar_seen.addr == 32'h60 && ar_seen.len == 8'd3 && ar_seen.size == 3'd3)
      else report("readback AR fields");
    assert (got_rdata == r.wdata) else report("line read differs from written line");
    assert (crit_cnt == 1 && crit_word == exp_word) else report("critical word of readback");
    close_test("line_readback", e);

    // line read, critical beat 2
    e = errors;
    r = make_req(1'b1, 1'b0, 32'hb0, 4'd12);
    run_req(r);
    assert (ar_seen.addr == 32'ha0 && ar_seen.len == 8'd3) else report("line AR fields");
    for (int k = 0; k < 4; k++) begin
      assert (got_rdata[k] == mem[20 + k]) else report("line read word");
    end
    assert (crit_cnt == 1 && crit_word == mem[22]) else report("critical word of line read");
    close_test("line_read", e);

    // single read
    e = errors;
    r = make_req(1'b0, 1'b0, 32'h1d8, 4'd7);
    run_req(r);
    assert (ar_seen.addr == 32'h1d8 && ar_seen.len == 8'd0) else report("single AR fields");
    assert (got_rdata[0] == mem[59]) else report("single read word");
    assert (crit_cnt == 1 && crit_word == mem[59]) else report("critical word of single read");
    close_test("single_read", e);

    $display("tests run: %0d, failed: %0d, errors: %0d", tests, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* axi_line_adapter.f */
axi_line_pkg.sv
axi_req_decode.sv
axi_burst_fsm.sv
axi_line_assembler.sv
axi_line_adapter.sv
axi_line_adapter_chk.sv
tb_axi_line_adapter.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_axi_line_adapter
FILELIST  = axi_line_adapter.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
